//--- verilog/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// machine word and register file geometry
`define MIPS_DATA_W     32
`define MIPS_REG_COUNT  32
`define MIPS_REG_W      5

// first fetch address out of reset
`define MIPS_RESET_PC   32'h0000_0000

// instruction field positions
// opcode spans OP_HI..OP_LO, funct is the low six bits
`define MIPS_OP_HI      31
`define MIPS_OP_LO      26
`define MIPS_RS_HI      25
`define MIPS_RT_HI      20
`define MIPS_RD_HI      15
// immediate sits in the low bits
`define MIPS_IMM_W      16

`endif

//--- verilog/mipsPkg.sv
package mipsPkg;

	// primary opcode field, instr[31:26]
	typedef enum logic [5:0] {
		opRtype = 6'b000000,
		opJ     = 6'b000010,
		opBeq   = 6'b000100,
		opAddi  = 6'b001000,
		opLw    = 6'b100011,
		opSw    = 6'b101011
	} opcodeT;

	// funct field for R-type, instr[5:0]
	typedef enum logic [5:0] {
		fnAdd = 6'b100000,
		fnSub = 6'b100010,
		fnAnd = 6'b100100,
		fnOr  = 6'b100101,
		fnSlt = 6'b101010
	} functT;

	// ALU operation select
	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr  = 3'd3,
		aluSlt = 3'd4
	} aluOpT;

	// writeback source
	typedef enum logic {
		resAlu = 1'b0,
		resMem = 1'b1
	} resultSelT;

endpackage

//--- verilog/mainDecoder.sv
`timescale 1ns/1ns

module mainDecoder (
	input  mipsPkg::opcodeT    opD,
	input  mipsPkg::functT     functD,
	output logic               regWriteD,
	output mipsPkg::resultSelT resultSelD,
	output logic               memWriteD,
	output logic               aluSrcD,
	output logic               regDstD,
	output logic               branchD,
	output logic               jumpD,
	output mipsPkg::aluOpT     aluOpD
);
	import mipsPkg::*;

	always_comb begin
		// defaults give a no-op
		regWriteD  = 1'b0;
		resultSelD = resAlu;
		memWriteD  = 1'b0;
		aluSrcD    = 1'b0;
		regDstD    = 1'b0;
		branchD    = 1'b0;
		jumpD      = 1'b0;
		aluOpD     = aluAdd;

		case (opD)
			opRtype: begin
				// rd destination, op from funct
				regDstD   = 1'b1;
				regWriteD = 1'b1;
				case (functD)
					fnAdd: aluOpD = aluAdd;
					fnSub: aluOpD = aluSub;
					fnAnd: aluOpD = aluAnd;
					fnOr:  aluOpD = aluOr;
					fnSlt: aluOpD = aluSlt;
					// unknown funct, also the all-zero bubble
					default: regWriteD = 1'b0;
				endcase
			end
			opAddi: begin
				regWriteD = 1'b1;
				aluSrcD   = 1'b1;
			end
			opLw: begin
				regWriteD  = 1'b1;
				aluSrcD    = 1'b1;
				resultSelD = resMem;
			end
			opSw: begin
				// address is rs + imm, data is rt
				memWriteD = 1'b1;
				aluSrcD   = 1'b1;
			end
			opBeq: begin
				// compare itself happens in decode
				branchD = 1'b1;
				aluOpD  = aluSub;
			end
			opJ: begin
				jumpD = 1'b1;
			end
			default: begin
				// unsupported opcode retires silently
				regWriteD = 1'b0;
			end
		endcase
	end

endmodule

//--- verilog/regFile.sv
`timescale 1ns/1ns
`include "mips_defs.svh"

module regFile (
	input  logic                    clk,
	input  logic                    writeEnable,
	input  logic [`MIPS_REG_W-1:0]  readAddrA,
	input  logic [`MIPS_REG_W-1:0]  readAddrB,
	input  logic [`MIPS_REG_W-1:0]  writeAddr,
	input  logic [`MIPS_DATA_W-1:0] writeData,
	output logic [`MIPS_DATA_W-1:0] readDataA,
	output logic [`MIPS_DATA_W-1:0] readDataB
);
	logic [`MIPS_DATA_W-1:0] regs [`MIPS_REG_COUNT];

	// r0 is never stored
	always_ff @(posedge clk) begin
		if (writeEnable && (writeAddr != '0)) begin
			regs[writeAddr] <= writeData;
		end
	end

	// r0 reads zero, same-cycle write wins over the array
	function automatic logic [`MIPS_DATA_W-1:0] readPort(input logic [`MIPS_REG_W-1:0] addr);
		if (addr == '0) begin
			return '0;
		end
		if (writeEnable && (writeAddr == addr)) begin
			return writeData;
		end
		return regs[addr];
	endfunction

	always_comb begin
		readDataA = readPort(readAddrA);
		readDataB = readPort(readAddrB);
	end

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ns
`include "mips_defs.svh"

module alu (
	input  logic [`MIPS_DATA_W-1:0] srcA,
	input  logic [`MIPS_DATA_W-1:0] srcB,
	input  mipsPkg::aluOpT          aluOp,
	output logic [`MIPS_DATA_W-1:0] result,
	output logic                    zero
);
	import mipsPkg::*;

	logic signed [`MIPS_DATA_W-1:0] srcASigned;
	logic signed [`MIPS_DATA_W-1:0] srcBSigned;

	// slt compares two's complement values
	assign srcASigned = srcA;
	assign srcBSigned = srcB;

	always_comb begin
		case (aluOp)
			aluAdd: begin
				result = srcA + srcB;
			end
			aluSub: begin
				result = srcA - srcB;
			end
			aluAnd: begin
				result = srcA & srcB;
			end
			aluOr: begin
				result = srcA | srcB;
			end
			aluSlt: begin
				// one in bit zero when a < b
				result = (srcASigned < srcBSigned) ? `MIPS_DATA_W'(1) : '0;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	// flag only, beq resolves in decode
	assign zero = (result == '0);

endmodule

//--- verilog/hazardUnit.sv
`timescale 1ns/1ns
`include "mips_defs.svh"

module hazardUnit (
	input  logic [`MIPS_REG_W-1:0] rsD,
	input  logic [`MIPS_REG_W-1:0] rtD,
	input  logic [`MIPS_REG_W-1:0] rsE,
	input  logic [`MIPS_REG_W-1:0] rtE,
	input  logic [`MIPS_REG_W-1:0] writeRegE,
	input  logic [`MIPS_REG_W-1:0] writeRegM,
	input  logic [`MIPS_REG_W-1:0] writeRegW,
	input  logic                   regWriteE,
	input  logic                   regWriteM,
	input  logic                   regWriteW,
	input  mipsPkg::resultSelT     resultSelE,
	input  mipsPkg::resultSelT     resultSelM,
	input  logic                   branchD,
	output logic                   forwardAD,
	output logic                   forwardBD,
	output logic [1:0]             forwardAE,
	output logic [1:0]             forwardBE,
	output logic                   stallF,
	output logic                   stallD,
	output logic                   flushE
);
	import mipsPkg::*;

	logic loadUseStall;
	logic branchStall;

	// execute operand select: 10 memory, 01 writeback, 00 register file
	// memory stage is younger so it wins
	function automatic logic [1:0] exeFwd(
		input logic [`MIPS_REG_W-1:0] src,
		input logic [`MIPS_REG_W-1:0] memDst,
		input logic                   memWen,
		input logic [`MIPS_REG_W-1:0] wbDst,
		input logic                   wbWen
	);
		logic [1:0] sel;
		sel = 2'b00;
		if ((src != '0) && memWen && (src == memDst)) begin
			sel = 2'b10;
		end else if ((src != '0) && wbWen && (src == wbDst)) begin
			sel = 2'b01;
		end
		return sel;
	endfunction

	assign forwardAE = exeFwd(rsE, writeRegM, regWriteM, writeRegW, regWriteW);
	assign forwardBE = exeFwd(rtE, writeRegM, regWriteM, writeRegW, regWriteW);

	// branch compare takes the memory-stage ALU result
	assign forwardAD = (rsD != '0) && regWriteM && (rsD == writeRegM);
	assign forwardBD = (rtD != '0) && regWriteM && (rtD == writeRegM);

	// lw in execute feeding the next instruction
	assign loadUseStall = (resultSelE == resMem) && ((rtE == rsD) || (rtE == rtD));

	// beq operand still in execute, or still a load in memory
	assign branchStall = branchD &&
		((regWriteE && ((writeRegE == rsD) || (writeRegE == rtD))) ||
		 ((resultSelM == resMem) && ((writeRegM == rsD) || (writeRegM == rtD))));

	// hold fetch and decode, bubble into execute
	assign stallF = loadUseStall || branchStall;
	assign stallD = loadUseStall || branchStall;
	assign flushE = loadUseStall || branchStall;

endmodule

//--- verilog/datapath.sv
`timescale 1ns/1ns
`include "mips_defs.svh"

module datapath (
	input  logic                    clk,
	input  logic                    reset,
	// instruction port
	output logic [`MIPS_DATA_W-1:0] pcF,
	input  logic [`MIPS_DATA_W-1:0] instrF,
	// data port
	output logic [`MIPS_DATA_W-1:0] aluOutM,
	output logic [`MIPS_DATA_W-1:0] writeDataM,
	output logic                    memWriteM,
	input  logic [`MIPS_DATA_W-1:0] readDataM,
	// decoder
	output mipsPkg::opcodeT         opD,
	output mipsPkg::functT          functD,
	input  logic                    regWriteD,
	input  mipsPkg::resultSelT      resultSelD,
	input  logic                    memWriteD,
	input  logic                    aluSrcD,
	input  logic                    regDstD,
	input  logic                    branchD,
	input  logic                    jumpD,
	input  mipsPkg::aluOpT          aluOpD,
	// hazard unit
	output logic [`MIPS_REG_W-1:0]  rsD,
	output logic [`MIPS_REG_W-1:0]  rtD,
	output logic [`MIPS_REG_W-1:0]  rsE,
	output logic [`MIPS_REG_W-1:0]  rtE,
	output logic [`MIPS_REG_W-1:0]  writeRegE,
	output logic [`MIPS_REG_W-1:0]  writeRegM,
	output logic [`MIPS_REG_W-1:0]  writeRegW,
	output logic                    regWriteE,
	output logic                    regWriteM,
	output logic                    regWriteW,
	output mipsPkg::resultSelT      resultSelE,
	output mipsPkg::resultSelT      resultSelM,
	input  logic                    forwardAD,
	input  logic                    forwardBD,
	input  logic [1:0]              forwardAE,
	input  logic [1:0]              forwardBE,
	input  logic                    stallF,
	input  logic                    stallD,
	input  logic                    flushE,
	// writeback debug
	output logic [`MIPS_DATA_W-1:0] debugWbPc,
	output logic                    debugWbRfWen,
	output logic [`MIPS_REG_W-1:0]  debugWbRfWnum,
	output logic [`MIPS_DATA_W-1:0] debugWbRfWdata
);
	import mipsPkg::*;

	// fetch
	logic [`MIPS_DATA_W-1:0] pcPlus4F;
	logic [`MIPS_DATA_W-1:0] pcNextF;
	// decode
	logic [`MIPS_DATA_W-1:0] instrD;
	logic [`MIPS_DATA_W-1:0] pcD;
	logic [`MIPS_DATA_W-1:0] pcPlus4D;
	logic [`MIPS_REG_W-1:0]  rdD;
	logic [`MIPS_DATA_W-1:0] signImmD;
	logic [`MIPS_DATA_W-1:0] readDataAD;
	logic [`MIPS_DATA_W-1:0] readDataBD;
	logic [`MIPS_DATA_W-1:0] cmpAD;
	logic [`MIPS_DATA_W-1:0] cmpBD;
	logic [`MIPS_DATA_W-1:0] branchTargetD;
	logic [`MIPS_DATA_W-1:0] jumpTargetD;
	logic                    branchTakenD;
	logic                    redirectD;
	// execute
	logic                    memWriteE;
	logic                    aluSrcE;
	logic                    regDstE;
	aluOpT                   aluOpE;
	logic [`MIPS_DATA_W-1:0] srcAE;
	logic [`MIPS_DATA_W-1:0] srcBE;
	logic [`MIPS_DATA_W-1:0] signImmE;
	logic [`MIPS_REG_W-1:0]  rdE;
	logic [`MIPS_DATA_W-1:0] pcE;
	logic [`MIPS_DATA_W-1:0] srcAFwdE;
	logic [`MIPS_DATA_W-1:0] writeDataE;
	logic [`MIPS_DATA_W-1:0] srcBAluE;
	logic [`MIPS_DATA_W-1:0] aluOutE;
	// memory
	logic [`MIPS_DATA_W-1:0] pcM;
	// writeback
	resultSelT               resultSelW;
	logic [`MIPS_DATA_W-1:0] aluOutW;
	logic [`MIPS_DATA_W-1:0] readDataW;
	logic [`MIPS_DATA_W-1:0] resultW;
	logic [`MIPS_DATA_W-1:0] pcW;

	// forward select, same encoding as the hazard unit
	function automatic logic [`MIPS_DATA_W-1:0] fwdMux(
		input logic [1:0]              sel,
		input logic [`MIPS_DATA_W-1:0] regVal,
		input logic [`MIPS_DATA_W-1:0] memVal,
		input logic [`MIPS_DATA_W-1:0] wbVal
	);
		case (sel)
			2'b10:   return memVal;
			2'b01:   return wbVal;
			default: return regVal;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// fetch
	assign pcPlus4F = pcF + `MIPS_DATA_W'(4);
	// redirect comes from decode, one cycle after fetch
	assign pcNextF = redirectD ? (jumpD ? jumpTargetD : branchTargetD) : pcPlus4F;

	always_ff @(posedge clk) begin
		if (reset) begin
			pcF <= `MIPS_RESET_PC;
		end else if (!stallF) begin
			pcF <= pcNextF;
		end
	end

	// F/D, all-zero word decodes as a no-op
	always_ff @(posedge clk) begin
		if (reset || redirectD) begin
			instrD <= '0;
		end else if (!stallD) begin
			instrD <= instrF;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallD) begin
			pcD <= pcF;
		end
	end

	//////////////////////////////////////////////////
	// decode
	assign opD      = opcodeT'(instrD[`MIPS_OP_HI:`MIPS_OP_LO]);
	assign functD   = functT'(instrD[`MIPS_OP_HI-`MIPS_OP_LO:0]);
	assign rsD      = instrD[`MIPS_RS_HI -: `MIPS_REG_W];
	assign rtD      = instrD[`MIPS_RT_HI -: `MIPS_REG_W];
	assign rdD      = instrD[`MIPS_RD_HI -: `MIPS_REG_W];
	assign signImmD = {{(`MIPS_DATA_W-`MIPS_IMM_W){instrD[`MIPS_IMM_W-1]}},
		instrD[`MIPS_IMM_W-1:0]};

	// targets relative to pc+4, no delay slot
	assign pcPlus4D      = pcD + `MIPS_DATA_W'(4);
	assign branchTargetD = pcPlus4D + {signImmD[`MIPS_DATA_W-3:0], 2'b00};
	assign jumpTargetD   = {pcPlus4D[`MIPS_DATA_W-1 -: 4], instrD[`MIPS_RS_HI:0], 2'b00};

	// writeback result bypasses inside the file
	regFile rf0 (
		.clk        (clk),
		.writeEnable(regWriteW),
		.readAddrA  (rsD),
		.readAddrB  (rtD),
		.writeAddr  (writeRegW),
		.writeData  (resultW),
		.readDataA  (readDataAD),
		.readDataB  (readDataBD)
	);

	// beq equality on forwarded operands
	assign cmpAD        = forwardAD ? aluOutM : readDataAD;
	assign cmpBD        = forwardBD ? aluOutM : readDataBD;
	assign branchTakenD = branchD && (cmpAD == cmpBD);
	// a stalled branch waits for its operands
	assign redirectD    = (branchTakenD || jumpD) && !stallD;

	// D/E control, bubble on flush
	always_ff @(posedge clk) begin
		if (reset || flushE) begin
			regWriteE  <= 1'b0;
			resultSelE <= resAlu;
			memWriteE  <= 1'b0;
		end else begin
			regWriteE  <= regWriteD;
			resultSelE <= resultSelD;
			memWriteE  <= memWriteD;
		end
	end

	always_ff @(posedge clk) begin
		aluSrcE  <= aluSrcD;
		regDstE  <= regDstD;
		aluOpE   <= aluOpD;
		srcAE    <= readDataAD;
		srcBE    <= readDataBD;
		signImmE <= signImmD;
		rsE      <= rsD;
		rtE      <= rtD;
		rdE      <= rdD;
		pcE      <= pcD;
	end

	//////////////////////////////////////////////////
	// execute
	assign srcAFwdE   = fwdMux(forwardAE, srcAE, aluOutM, resultW);
	assign writeDataE = fwdMux(forwardBE, srcBE, aluOutM, resultW);
	assign srcBAluE   = aluSrcE ? signImmE : writeDataE;
	// rd for R-type, rt otherwise
	assign writeRegE  = regDstE ? rdE : rtE;

	alu alu0 (
		.srcA  (srcAFwdE),
		.srcB  (srcBAluE),
		.aluOp (aluOpE),
		.result(aluOutE),
		.zero  ()
	);

	// E/M
	always_ff @(posedge clk) begin
		if (reset) begin
			regWriteM  <= 1'b0;
			resultSelM <= resAlu;
			memWriteM  <= 1'b0;
		end else begin
			regWriteM  <= regWriteE;
			resultSelM <= resultSelE;
			memWriteM  <= memWriteE;
		end
	end

	always_ff @(posedge clk) begin
		aluOutM    <= aluOutE;
		writeDataM <= writeDataE;
		writeRegM  <= writeRegE;
		pcM        <= pcE;
	end

	//////////////////////////////////////////////////
	// memory to writeback
	always_ff @(posedge clk) begin
		if (reset) begin
			regWriteW  <= 1'b0;
			resultSelW <= resAlu;
		end else begin
			regWriteW  <= regWriteM;
			resultSelW <= resultSelM;
		end
	end

	always_ff @(posedge clk) begin
		aluOutW   <= aluOutM;
		readDataW <= readDataM;
		writeRegW <= writeRegM;
		pcW       <= pcM;
	end

	assign resultW = (resultSelW == resMem) ? readDataW : aluOutW;

	// one retirement per cycle with wen high
	assign debugWbPc      = pcW;
	assign debugWbRfWen   = regWriteW;
	assign debugWbRfWnum  = writeRegW;
	// r0 writes report zero, matching the file
	assign debugWbRfWdata = (writeRegW == '0) ? '0 : resultW;

endmodule

//--- verilog/mipsCore.sv
`timescale 1ns/1ns
`include "mips_defs.svh"

module mipsCore (
	input  logic                    clk,
	input  logic                    reset,
	// instruction port
	output logic [`MIPS_DATA_W-1:0] pcF,
	input  logic [`MIPS_DATA_W-1:0] instrF,
	// data port
	output logic [`MIPS_DATA_W-1:0] aluOutM,
	output logic [`MIPS_DATA_W-1:0] writeDataM,
	output logic                    memWriteM,
	input  logic [`MIPS_DATA_W-1:0] readDataM,
	// writeback debug
	output logic [`MIPS_DATA_W-1:0] debugWbPc,
	output logic                    debugWbRfWen,
	output logic [`MIPS_REG_W-1:0]  debugWbRfWnum,
	output logic [`MIPS_DATA_W-1:0] debugWbRfWdata
);
	import mipsPkg::*;

	// decoder
	opcodeT    opD;
	functT     functD;
	logic      regWriteD;
	resultSelT resultSelD;
	logic      memWriteD;
	logic      aluSrcD;
	logic      regDstD;
	logic      branchD;
	logic      jumpD;
	aluOpT     aluOpD;

	// hazard unit
	logic [`MIPS_REG_W-1:0] rsD;
	logic [`MIPS_REG_W-1:0] rtD;
	logic [`MIPS_REG_W-1:0] rsE;
	logic [`MIPS_REG_W-1:0] rtE;
	logic [`MIPS_REG_W-1:0] writeRegE;
	logic [`MIPS_REG_W-1:0] writeRegM;
	logic [`MIPS_REG_W-1:0] writeRegW;
	logic                   regWriteE;
	logic                   regWriteM;
	logic                   regWriteW;
	resultSelT              resultSelE;
	resultSelT              resultSelM;
	logic                   forwardAD;
	logic                   forwardBD;
	logic [1:0]             forwardAE;
	logic [1:0]             forwardBE;
	logic                   stallF;
	logic                   stallD;
	logic                   flushE;

	// names line up across all three blocks
	mainDecoder md0 (.*);

	hazardUnit hu0 (.*);

	datapath dp0 (.*);

endmodule

//--- sim/mipsCore_properties.sv
`timescale 1ns/1ns
`include "mips_defs.svh"

module mipsCoreProps (
	input logic                    clk,
	input logic                    reset,
	input logic [`MIPS_DATA_W-1:0] pcF,
	input logic                    memWriteM,
	input logic                    debugWbRfWen,
	input logic [`MIPS_REG_W-1:0]  debugWbRfWnum,
	input logic [`MIPS_DATA_W-1:0] debugWbRfWdata,
	input logic                    stallF,
	input logic                    stallD
);

	// pipe holds only bubbles right after a reset edge
	idleAfterReset: assert property (@(posedge clk) reset |=> (!memWriteM && !debugWbRfWen))
		else $error("store or writeback active in the cycle after reset");

	// a stalled fetch keeps its address
	stallHoldsPc: assert property (@(posedge clk) disable iff (reset) stallF |=> $stable(pcF))
		else $error("fetch address moved during a stall");

	// r0 may retire, but only as zero
	zeroRegClean: assert property (@(posedge clk) disable iff (reset)
		(debugWbRfWen && (debugWbRfWnum == '0)) |-> (debugWbRfWdata == '0))
		else $error("register zero reported with nonzero data");

endmodule

// attach to every core instance
bind mipsCore mipsCoreProps props0 (.*);

//--- sim/mipsCoreTb.sv
`timescale 1ns/1ns
`include "mips_defs.svh"

module mipsCoreTb;
	import mipsPkg::*;

	localparam int MaxRows     = 32;
	localparam int ResetCycles = 16;
	localparam int DrainCycles = 8;

	logic                    clk;
	logic                    reset;
	logic [`MIPS_DATA_W-1:0] pcF;
	logic [`MIPS_DATA_W-1:0] instrF;
	logic [`MIPS_DATA_W-1:0] aluOutM;
	logic [`MIPS_DATA_W-1:0] writeDataM;
	logic                    memWriteM;
	logic [`MIPS_DATA_W-1:0] readDataM;
	logic [`MIPS_DATA_W-1:0] debugWbPc;
	logic                    debugWbRfWen;
	logic [`MIPS_REG_W-1:0]  debugWbRfWnum;
	logic [`MIPS_DATA_W-1:0] debugWbRfWdata;

	// one row per instruction word, row index is the word address
	string                   rowName [MaxRows];
	logic [`MIPS_DATA_W-1:0] rowInstr [MaxRows];
	bit                      rowWen [MaxRows];
	logic [`MIPS_REG_W-1:0]  rowReg [MaxRows];
	logic [`MIPS_DATA_W-1:0] rowVal [MaxRows];
	int                      rowCount;
	// data words expected once the program is done
	string                   wordName [8];
	int                      wordAddr [8];
	logic [`MIPS_DATA_W-1:0] wordVal [8];
	int                      wordCount;

	logic [`MIPS_DATA_W-1:0] instrMem [64];
	logic [`MIPS_DATA_W-1:0] dataMem [64];

	int    passCount;
	int    failCount;
	int    retireCount;
	int    expectedRetires;
	string waitingFor;
	bit    tableReady;

	mipsCore dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// memory models
	// both reads combinational, word addressed
	assign instrF    = instrMem[pcF[7:2]];
	assign readDataM = dataMem[aluOutM[7:2]];

	// store lands at the edge ending its memory cycle
	always @(posedge clk) begin
		if (memWriteM) begin
			dataMem[aluOutM[7:2]] <= writeDataM;
		end
	end

	// every writeback pulse, expected or not
	always @(negedge clk) begin
		if (debugWbRfWen) begin
			retireCount++;
		end
	end

	//////////////////////////////////////////////////
	// instruction encoders, assembly operand order
	function automatic logic [31:0] encodeR(input functT fn, input int rd, input int rs,
		input int rt);
		return {opRtype, `MIPS_REG_W'(rs), `MIPS_REG_W'(rt), `MIPS_REG_W'(rd), 5'd0, fn};
	endfunction

	// beq passes rt first as well
	function automatic logic [31:0] encodeI(input opcodeT op, input int rt, input int rs,
		input logic [`MIPS_IMM_W-1:0] imm);
		return {op, `MIPS_REG_W'(rs), `MIPS_REG_W'(rt), imm};
	endfunction

	function automatic logic [31:0] encodeJ(input logic [31:0] target);
		return {opJ, target[27:2]};
	endfunction

	// preset data word, tagged with its own byte address
	function automatic logic [31:0] fillWord(input int addr);
		return {16'hDA7A, 16'(addr)};
	endfunction

	task automatic addWrite(input string name, input logic [31:0] instr, input int rd,
		input logic [31:0] val);
		rowName[rowCount]  = name;
		rowInstr[rowCount] = instr;
		rowWen[rowCount]   = 1'b1;
		rowReg[rowCount]   = `MIPS_REG_W'(rd);
		rowVal[rowCount]   = val;
		rowCount++;
		expectedRetires++;
	endtask

	// stores, branches and words that must never retire
	task automatic addSilent(input string name, input logic [31:0] instr);
		rowName[rowCount]  = name;
		rowInstr[rowCount] = instr;
		rowWen[rowCount]   = 1'b0;
		rowReg[rowCount]   = '0;
		rowVal[rowCount]   = '0;
		rowCount++;
	endtask

	task automatic addWordCheck(input string name, input int addr, input logic [31:0] val);
		wordName[wordCount] = name;
		wordAddr[wordCount] = addr;
		wordVal[wordCount]  = val;
		wordCount++;
	endtask

	task automatic buildProgram();
		// dependent ALU chain, operands from M and W
		addWrite("addi r1", encodeI(opAddi, 1, 0, 16'd7), 1, 32'd7);
		addWrite("addi r2 negative", encodeI(opAddi, 2, 0, 16'hFFFD), 2, 32'hFFFF_FFFD);
		addWrite("add fwd mem wb", encodeR(fnAdd, 3, 1, 2), 3, 32'd4);
		addWrite("sub", encodeR(fnSub, 4, 3, 1), 4, 32'hFFFF_FFFD);
		addWrite("and", encodeR(fnAnd, 5, 4, 3), 5, 32'd4);
		addWrite("or", encodeR(fnOr, 6, 5, 2), 6, 32'hFFFF_FFFD);
		addWrite("slt signed true", encodeR(fnSlt, 7, 6, 1), 7, 32'd1);
		addWrite("slt signed false", encodeR(fnSlt, 8, 1, 6), 8, 32'd0);
		// load-use bubble
		addWrite("lw preset word", encodeI(opLw, 9, 0, 16'h0040), 9, 32'hDA7A_0040);
		addWrite("load use add", encodeR(fnAdd, 10, 9, 1), 10, 32'hDA7A_0047);
		// store then reload
		addSilent("sw r10", encodeI(opSw, 10, 0, 16'h0044));
		addWrite("lw after sw", encodeI(opLw, 11, 0, 16'h0044), 11, 32'hDA7A_0047);
		addSilent("sw r7", encodeI(opSw, 7, 0, 16'h0048));
		// r1 != r7, falls through
		addSilent("beq not taken", encodeI(opBeq, 7, 1, 16'd1));
		addWrite("after beq not taken", encodeI(opAddi, 12, 0, 16'h0012), 12, 32'h12);
		// r4 == r2, skips one word
		addSilent("beq taken", encodeI(opBeq, 2, 4, 16'd1));
		addSilent("skipped by beq", encodeI(opAddi, 13, 0, 16'h0013));
		addWrite("beq target", encodeI(opAddi, 14, 0, 16'h0014), 14, 32'h14);
		// operand still in execute, one stall then forward from M
		addWrite("addi r15", encodeI(opAddi, 15, 1, 16'd0), 15, 32'd7);
		addSilent("beq after alu", encodeI(opBeq, 1, 15, 16'd1));
		addSilent("skipped by stalled beq", encodeI(opAddi, 16, 0, 16'h0016));
		addSilent("j forward", encodeJ(32'h0000_0060));
		addSilent("skipped by j", encodeI(opAddi, 17, 0, 16'h0017));
		addSilent("never fetched", encodeI(opAddi, 18, 0, 16'h0018));
		addWrite("j target", encodeI(opAddi, 19, 0, 16'h0019), 19, 32'h19);
		// r0 retires as zero and still reads zero
		addWrite("write r0", encodeI(opAddi, 0, 0, 16'h0055), 0, 32'd0);
		addWrite("read r0 add", encodeR(fnAdd, 20, 0, 19), 20, 32'h19);
		addWrite("read r0 and", encodeR(fnAnd, 21, 20, 0), 21, 32'd0);
		addSilent("sw r20", encodeI(opSw, 20, 0, 16'h004C));

		addWordCheck("preset word kept", 32'h40, 32'hDA7A_0040);
		addWordCheck("sw r10 stored", 32'h44, 32'hDA7A_0047);
		addWordCheck("sw r7 stored", 32'h48, 32'd1);
		addWordCheck("sw r20 stored", 32'h4C, 32'h19);
	endtask

	task automatic loadMemories();
		for (int i = 0; i < 64; i++) begin
			// words past the program are nops
			instrMem[i] = (i < rowCount) ? rowInstr[i] : '0;
			dataMem[i]  = fillWord(i * 4);
		end
	endtask

	//////////////////////////////////////////////////
	// checkers
	task automatic checkRetire(input int idx);
		bit          ok;
		logic [31:0] expPc;
		ok         = 1'b1;
		expPc      = idx * 4;
		waitingFor = rowName[idx];
		@(negedge clk);
		while (!debugWbRfWen) begin
			@(negedge clk);
		end
		assert (debugWbRfWnum == rowReg[idx]) else begin
			$display("ERROR %s register expected %0d actual %0d", rowName[idx],
				rowReg[idx], debugWbRfWnum);
			ok = 1'b0;
		end
		assert (debugWbRfWdata == rowVal[idx]) else begin
			$display("ERROR %s data expected %h actual %h", rowName[idx], rowVal[idx],
				debugWbRfWdata);
			ok = 1'b0;
		end
		// pc shows program order and jump targets
		assert (debugWbPc == expPc) else begin
			$display("ERROR %s pc expected %h actual %h", rowName[idx], expPc, debugWbPc);
			ok = 1'b0;
		end
		if (ok) begin
			passCount++;
			$display("ok    %s", rowName[idx]);
		end else begin
			failCount++;
			$display("fail  %s", rowName[idx]);
		end
	endtask

	task automatic checkWord(input int idx);
		logic [31:0] actual;
		actual = dataMem[wordAddr[idx] / 4];
		assert (actual == wordVal[idx]) else begin
			$display("ERROR %s expected %h actual %h", wordName[idx], wordVal[idx], actual);
		end
		if (actual == wordVal[idx]) begin
			passCount++;
			$display("ok    %s", wordName[idx]);
		end else begin
			failCount++;
			$display("fail  %s", wordName[idx]);
		end
	endtask

	//////////////////////////////////////////////////
	initial begin
		reset = 1'b1;
		buildProgram();
		loadMemories();
		tableReady = 1'b1;
		repeat (ResetCycles) @(negedge clk);
		reset = 1'b0;

		for (int i = 0; i < rowCount; i++) begin
			if (rowWen[i]) begin
				checkRetire(i);
			end
		end

		// let the last store leave the pipe
		waitingFor = "pipeline drain";
		repeat (DrainCycles) @(negedge clk);
		for (int i = 0; i < wordCount; i++) begin
			checkWord(i);
		end

		// skipped words must not have retired
		assert (retireCount == expectedRetires) else begin
			$display("ERROR retire count expected %0d actual %0d", expectedRetires,
				retireCount);
		end
		if (retireCount == expectedRetires) begin
			passCount++;
			$display("ok    retire count");
		end else begin
			failCount++;
			$display("fail  retire count");
		end

		$display("tests passed %0d, failed %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	// watchdog, eight cycles per program word plus reset and drain
	initial begin
		wait (tableReady);
		repeat (ResetCycles + rowCount * 8 + DrainCycles) @(posedge clk);
		$display("timeout: %s never retired", waitingFor);
		$display("** FAIL **");
		$finish;
	end

endmodule

//--- mipsCore.f
+incdir+verilog
verilog/mipsPkg.sv
verilog/mainDecoder.sv
verilog/regFile.sv
verilog/alu.sv
verilog/hazardUnit.sv
verilog/datapath.sv
verilog/mipsCore.sv
sim/mipsCore_properties.sv
sim/mipsCoreTb.sv

//--- Bender.yml
package:
  name: mips_core

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mipsPkg.sv
      - verilog/mainDecoder.sv
      - verilog/regFile.sv
      - verilog/alu.sv
      - verilog/hazardUnit.sv
      - verilog/datapath.sv
      - verilog/mipsCore.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/mipsCore_properties.sv
      - sim/mipsCoreTb.sv
